//--- rtl/ooo_settings.svh
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// data path
`define OOO_XLEN 32

// register files
`define OOO_LOG_REGS 32
`define OOO_PHY_REGS 64

// window sizes
`define OOO_IQ_DEPTH 8
`define OOO_ROB_DEPTH 16   // kept below the 64 - 32 free registers

`endif

//--- rtl/ooo_pkg.sv
`default_nettype none
`include "ooo_settings.svh"

package ooo_pkg;

    typedef logic [`OOO_XLEN-1:0]               word_t;
    typedef logic [$clog2(`OOO_LOG_REGS)-1:0]   log_reg_t;
    typedef logic [$clog2(`OOO_PHY_REGS)-1:0]   phy_reg_t;
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0]  rob_tag_t;

    // shifts take b[4:0] and slt is signed
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_t;

endpackage

`default_nettype wire

//--- rtl/free_list.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_settings.svh"

module free_list (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    alloc,
    input  wire                    release_valid,
    input  wire ooo_pkg::phy_reg_t release_phy,
    output ooo_pkg::phy_reg_t      alloc_phy
);
    import ooo_pkg::*;

    localparam int DEPTH = `OOO_PHY_REGS - `OOO_LOG_REGS;
    localparam int PW    = $clog2(DEPTH);

    phy_reg_t      slots [DEPTH];
    logic [PW-1:0] head;
    logic [PW-1:0] tail;
    logic [PW:0]   count;

    assign alloc_phy = slots[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            // spare registers 32..63 start out free
            for (int i = 0; i < DEPTH; i++)
                slots[i] <= phy_reg_t'(i + `OOO_LOG_REGS);
            head  <= '0;
            tail  <= '0;
            count <= (PW+1)'(DEPTH);
        end else begin
            if (alloc)
                head <= head + 1'b1;
            if (release_valid) begin
                slots[tail] <= release_phy;
                tail        <= tail + 1'b1;
            end
            count <= count + (PW+1)'(release_valid) - (PW+1)'(alloc);
        end
    end

    // rob depth is meant to keep this from ever happening
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        alloc |-> count != '0)
        else $error("free list: allocation while empty");

endmodule

`default_nettype wire

//--- rtl/rename_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_settings.svh"

module rename_stage (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    inst_valid,
    input  wire ooo_pkg::alu_op_t  inst_op,
    input  wire ooo_pkg::log_reg_t inst_rs1,
    input  wire ooo_pkg::log_reg_t inst_rs2,
    input  wire ooo_pkg::log_reg_t inst_rd,
    input  wire                    inst_use_imm,
    input  wire ooo_pkg::word_t    inst_imm,
    input  wire                    iq_full,
    input  wire                    rob_full,
    input  wire                    result_valid,
    input  wire ooo_pkg::phy_reg_t result_phy,
    input  wire ooo_pkg::word_t    result_value,
    input  wire                    free_valid,
    input  wire ooo_pkg::phy_reg_t free_phy,
    output logic                   stall,
    output logic                   dispatch,
    output ooo_pkg::phy_reg_t      src1_phy,
    output ooo_pkg::phy_reg_t      src2_phy,
    output logic                   src1_ready,
    output logic                   src2_ready,
    output ooo_pkg::word_t         src1_value,
    output ooo_pkg::word_t         src2_value,
    output ooo_pkg::phy_reg_t      dest_phy,
    output ooo_pkg::phy_reg_t      stale_phy,
    output ooo_pkg::alu_op_t       disp_op,
    output logic                   disp_use_imm,
    output ooo_pkg::word_t         disp_imm
);
    import ooo_pkg::*;

    phy_reg_t                 rat [`OOO_LOG_REGS];
    word_t                    prf [`OOO_PHY_REGS];
    logic [`OOO_PHY_REGS-1:0] ready;
    phy_reg_t                 alloc_phy;
    logic                     writes_rd;
    logic                     bcast_ok;
    logic                     hit1;
    logic                     hit2;

    free_list u_free_list (
        .clk           (clk),
        .rst           (rst),
        .alloc         (dispatch && writes_rd),
        .release_valid (free_valid),
        .release_phy   (free_phy),
        .alloc_phy     (alloc_phy)
    );

    assign stall     = iq_full | rob_full;
    assign dispatch  = inst_valid & ~stall;
    assign writes_rd = inst_rd != '0;
    assign bcast_ok  = result_valid && result_phy != '0;   // phy 0 swallows x0 writes

    assign src1_phy = rat[inst_rs1];
    assign src2_phy = rat[inst_rs2];

    // catch a result landing in the dispatch cycle
    assign hit1 = bcast_ok && result_phy == src1_phy;
    assign hit2 = bcast_ok && result_phy == src2_phy;

    assign src1_ready = ready[src1_phy] | hit1;
    assign src2_ready = ready[src2_phy] | hit2;
    assign src1_value = hit1 ? result_value : prf[src1_phy];
    assign src2_value = hit2 ? result_value : prf[src2_phy];

    assign dest_phy     = writes_rd ? alloc_phy : '0;
    assign stale_phy    = rat[inst_rd];
    assign disp_op      = inst_op;
    assign disp_use_imm = inst_use_imm;
    assign disp_imm     = inst_imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `OOO_LOG_REGS; i++)
                rat[i] <= phy_reg_t'(i);
            for (int i = 0; i < `OOO_PHY_REGS; i++)
                prf[i] <= '0;
            ready <= '1;
        end else begin
            if (bcast_ok) begin
                prf[result_phy]   <= result_value;
                ready[result_phy] <= 1'b1;
            end
            if (dispatch && writes_rd) begin
                rat[inst_rd]     <= alloc_phy;
                ready[alloc_phy] <= 1'b0;   // pending until its broadcast
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_settings.svh"

module issue_queue (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    dispatch,
    input  wire ooo_pkg::phy_reg_t src1_phy,
    input  wire ooo_pkg::phy_reg_t src2_phy,
    input  wire                    src1_ready,
    input  wire                    src2_ready,
    input  wire ooo_pkg::word_t    src1_value,
    input  wire ooo_pkg::word_t    src2_value,
    input  wire ooo_pkg::phy_reg_t dest_phy,
    input  wire ooo_pkg::alu_op_t  disp_op,
    input  wire                    disp_use_imm,
    input  wire ooo_pkg::word_t    disp_imm,
    input  wire ooo_pkg::rob_tag_t rob_tail,
    input  wire                    result_valid,
    input  wire ooo_pkg::phy_reg_t result_phy,
    input  wire ooo_pkg::word_t    result_value,
    output logic                   iq_full,
    output logic                   issue_valid,
    output ooo_pkg::alu_op_t       issue_op,
    output ooo_pkg::word_t         issue_a,
    output ooo_pkg::word_t         issue_b,
    output ooo_pkg::phy_reg_t      issue_phy,
    output ooo_pkg::rob_tag_t      issue_tag
);
    import ooo_pkg::*;

    localparam int DEPTH = `OOO_IQ_DEPTH;
    localparam int IW    = $clog2(DEPTH);

    logic [DEPTH-1:0] valid;
    logic [DEPTH-1:0] rdy1;
    logic [DEPTH-1:0] rdy2;
    logic [DEPTH-1:0] use_imm;
    logic [DEPTH-1:0] wake1;
    logic [DEPTH-1:0] wake2;
    alu_op_t          op   [DEPTH];
    phy_reg_t         tag1 [DEPTH];
    phy_reg_t         tag2 [DEPTH];
    word_t            val1 [DEPTH];
    word_t            val2 [DEPTH];
    word_t            imm  [DEPTH];
    phy_reg_t         dst  [DEPTH];
    rob_tag_t         tag  [DEPTH];
    logic [IW-1:0]    free_idx;
    logic [IW-1:0]    iss_idx;

    assign iq_full = &valid;

    always_comb begin
        free_idx    = '0;
        iss_idx     = '0;
        issue_valid = 1'b0;
        // walk downward so the lowest index wins
        for (int i = DEPTH - 1; i >= 0; i--) begin
            wake1[i] = result_valid && valid[i] && !rdy1[i] && tag1[i] == result_phy;
            wake2[i] = result_valid && valid[i] && !rdy2[i] && tag2[i] == result_phy;
            if (!valid[i])
                free_idx = IW'(i);
            if (valid[i] && rdy1[i] && (rdy2[i] || use_imm[i])) begin
                iss_idx     = IW'(i);
                issue_valid = 1'b1;
            end
        end
    end

    assign issue_op  = op[iss_idx];
    assign issue_a   = val1[iss_idx];
    assign issue_b   = use_imm[iss_idx] ? imm[iss_idx] : val2[iss_idx];
    assign issue_phy = dst[iss_idx];
    assign issue_tag = tag[iss_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else begin
            if (issue_valid)
                valid[iss_idx] <= 1'b0;
            if (dispatch)
                valid[free_idx] <= 1'b1;
        end
    end

    // operand capture and new entries
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (wake1[i]) begin
                rdy1[i] <= 1'b1;
                val1[i] <= result_value;
            end
            if (wake2[i]) begin
                rdy2[i] <= 1'b1;
                val2[i] <= result_value;
            end
        end
        if (dispatch) begin
            op[free_idx]      <= disp_op;
            tag1[free_idx]    <= src1_phy;
            tag2[free_idx]    <= src2_phy;
            rdy1[free_idx]    <= src1_ready;
            rdy2[free_idx]    <= src2_ready;
            val1[free_idx]    <= src1_value;
            val2[free_idx]    <= src2_value;
            use_imm[free_idx] <= disp_use_imm;
            imm[free_idx]     <= disp_imm;
            dst[free_idx]     <= dest_phy;
            tag[free_idx]     <= rob_tail;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        dispatch |-> !iq_full)
        else $error("issue queue: dispatch while full");

endmodule

`default_nettype wire

//--- rtl/alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    issue_valid,
    input  wire ooo_pkg::alu_op_t  issue_op,
    input  wire ooo_pkg::word_t    issue_a,
    input  wire ooo_pkg::word_t    issue_b,
    input  wire ooo_pkg::phy_reg_t issue_phy,
    input  wire ooo_pkg::rob_tag_t issue_tag,
    output logic                   result_valid,
    output ooo_pkg::phy_reg_t      result_phy,
    output ooo_pkg::rob_tag_t      result_tag,
    output ooo_pkg::word_t         result_value
);
    import ooo_pkg::*;

    word_t alu_out;

    always_comb begin
        unique case (issue_op)
            ALU_ADD: alu_out = issue_a + issue_b;
            ALU_SUB: alu_out = issue_a - issue_b;
            ALU_AND: alu_out = issue_a & issue_b;
            ALU_OR:  alu_out = issue_a | issue_b;
            ALU_XOR: alu_out = issue_a ^ issue_b;
            ALU_SLL: alu_out = issue_a << issue_b[4:0];
            ALU_SRL: alu_out = issue_a >> issue_b[4:0];
            ALU_SLT: alu_out = word_t'($signed(issue_a) < $signed(issue_b));
        endcase
    end

    // single shared result bus
    always_ff @(posedge clk) begin
        if (rst)
            result_valid <= 1'b0;
        else
            result_valid <= issue_valid;
    end

    always_ff @(posedge clk) begin
        result_phy   <= issue_phy;
        result_tag   <= issue_tag;
        result_value <= alu_out;
    end

endmodule

`default_nettype wire

//--- rtl/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_settings.svh"

module reorder_buffer (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    dispatch,
    input  wire ooo_pkg::log_reg_t inst_rd,
    input  wire ooo_pkg::phy_reg_t dest_phy,
    input  wire ooo_pkg::phy_reg_t stale_phy,
    input  wire                    result_valid,
    input  wire ooo_pkg::rob_tag_t result_tag,
    input  wire ooo_pkg::word_t    result_value,
    output ooo_pkg::rob_tag_t      rob_tail,
    output logic                   rob_full,
    output logic                   free_valid,
    output ooo_pkg::phy_reg_t      free_phy,
    output logic                   commit_valid,
    output ooo_pkg::log_reg_t      commit_rd,
    output ooo_pkg::word_t         commit_value
);
    import ooo_pkg::*;

    localparam int DEPTH = `OOO_ROB_DEPTH;
    localparam int CW    = $clog2(DEPTH) + 1;

    log_reg_t         rd    [DEPTH];
    phy_reg_t         stale [DEPTH];
    word_t            value [DEPTH];
    logic [DEPTH-1:0] writes;    // slot renamed a real register
    logic [DEPTH-1:0] done;
    rob_tag_t         head;
    rob_tag_t         tail;
    logic [CW-1:0]    count;

    assign rob_tail     = tail;
    assign rob_full     = count == CW'(DEPTH);
    assign commit_valid = count != '0 && done[head];
    assign commit_rd    = rd[head];
    assign commit_value = value[head];
    assign free_valid   = commit_valid && writes[head];   // old mapping now dead
    assign free_phy     = stale[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (dispatch) begin
                tail       <= tail + 1'b1;
                done[tail] <= 1'b0;
            end
            if (result_valid)
                done[result_tag] <= 1'b1;
            if (commit_valid)
                head <= head + 1'b1;
            count <= count + CW'(dispatch) - CW'(commit_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            rd[tail]     <= inst_rd;
            stale[tail]  <= stale_phy;
            writes[tail] <= dest_phy != '0;
        end
        if (result_valid)
            value[result_tag] <= result_value;
    end

    // tag must fall between head and tail
    a_tag_live: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> CW'(rob_tag_t'(result_tag - head)) < count)
        else $error("reorder buffer: result for an empty slot");

endmodule

`default_nettype wire

//--- rtl/ooo_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_top (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    inst_valid,
    input  wire ooo_pkg::alu_op_t  inst_op,
    input  wire ooo_pkg::log_reg_t inst_rs1,
    input  wire ooo_pkg::log_reg_t inst_rs2,
    input  wire ooo_pkg::log_reg_t inst_rd,
    input  wire                    inst_use_imm,
    input  wire ooo_pkg::word_t    inst_imm,
    output logic                   stall,
    output logic                   commit_valid,
    output ooo_pkg::log_reg_t      commit_rd,
    output ooo_pkg::word_t         commit_value
);
    import ooo_pkg::*;

    // rename to issue queue and rob
    logic     dispatch;
    phy_reg_t src1_phy;
    phy_reg_t src2_phy;
    logic     src1_ready;
    logic     src2_ready;
    word_t    src1_value;
    word_t    src2_value;
    phy_reg_t dest_phy;
    phy_reg_t stale_phy;
    alu_op_t  disp_op;
    logic     disp_use_imm;
    word_t    disp_imm;
    logic     iq_full;
    logic     rob_full;
    rob_tag_t rob_tail;

    // issue, broadcast, release
    logic     issue_valid;
    alu_op_t  issue_op;
    word_t    issue_a;
    word_t    issue_b;
    phy_reg_t issue_phy;
    rob_tag_t issue_tag;
    logic     result_valid;
    phy_reg_t result_phy;
    rob_tag_t result_tag;
    word_t    result_value;
    logic     free_valid;
    phy_reg_t free_phy;

    rename_stage u_rename_stage (
        .clk(clk), .rst(rst),
        .inst_valid(inst_valid), .inst_op(inst_op),
        .inst_rs1(inst_rs1), .inst_rs2(inst_rs2), .inst_rd(inst_rd),
        .inst_use_imm(inst_use_imm), .inst_imm(inst_imm),
        .iq_full(iq_full), .rob_full(rob_full),
        .result_valid(result_valid), .result_phy(result_phy), .result_value(result_value),
        .free_valid(free_valid), .free_phy(free_phy),
        .stall(stall), .dispatch(dispatch),
        .src1_phy(src1_phy), .src2_phy(src2_phy),
        .src1_ready(src1_ready), .src2_ready(src2_ready),
        .src1_value(src1_value), .src2_value(src2_value),
        .dest_phy(dest_phy), .stale_phy(stale_phy),
        .disp_op(disp_op), .disp_use_imm(disp_use_imm), .disp_imm(disp_imm)
    );

    issue_queue u_issue_queue (
        .clk(clk), .rst(rst), .dispatch(dispatch),
        .src1_phy(src1_phy), .src2_phy(src2_phy),
        .src1_ready(src1_ready), .src2_ready(src2_ready),
        .src1_value(src1_value), .src2_value(src2_value),
        .dest_phy(dest_phy), .disp_op(disp_op),
        .disp_use_imm(disp_use_imm), .disp_imm(disp_imm), .rob_tail(rob_tail),
        .result_valid(result_valid), .result_phy(result_phy), .result_value(result_value),
        .iq_full(iq_full), .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_a(issue_a), .issue_b(issue_b),
        .issue_phy(issue_phy), .issue_tag(issue_tag)
    );

    alu_exec u_alu_exec (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_a(issue_a), .issue_b(issue_b),
        .issue_phy(issue_phy), .issue_tag(issue_tag),
        .result_valid(result_valid), .result_phy(result_phy),
        .result_tag(result_tag), .result_value(result_value)
    );

    reorder_buffer u_reorder_buffer (
        .clk(clk), .rst(rst), .dispatch(dispatch), .inst_rd(inst_rd),
        .dest_phy(dest_phy), .stale_phy(stale_phy),
        .result_valid(result_valid), .result_tag(result_tag), .result_value(result_value),
        .rob_tail(rob_tail), .rob_full(rob_full),
        .free_valid(free_valid), .free_phy(free_phy),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value)
    );

endmodule

`default_nettype wire

//--- sim/tb_ooo_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_settings.svh"

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int CLK_NS  = 8;
    localparam int N_INSTR = 300;

    logic     clk;
    logic     rst;
    logic     inst_valid;
    alu_op_t  inst_op;
    log_reg_t inst_rs1;
    log_reg_t inst_rs2;
    log_reg_t inst_rd;
    logic     inst_use_imm;
    word_t    inst_imm;
    logic     stall;
    logic     commit_valid;
    log_reg_t commit_rd;
    word_t    commit_value;

    integer   seed;
    word_t    regs [`OOO_LOG_REGS];   // architectural state, program order
    log_reg_t exp_rd [$];
    word_t    exp_value [$];
    int       sent;
    int       committed;
    int       stall_cycles;
    int       rd_errors;
    int       value_errors;
    int       other_errors;

    ooo_core_top u_dut (
        .clk(clk), .rst(rst),
        .inst_valid(inst_valid), .inst_op(inst_op),
        .inst_rs1(inst_rs1), .inst_rs2(inst_rs2), .inst_rd(inst_rd),
        .inst_use_imm(inst_use_imm), .inst_imm(inst_imm),
        .stall(stall),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // mostly x0..x4 so instructions depend on each other
    function automatic log_reg_t pick_reg();
        if (rand_below(4) != 0)
            return log_reg_t'(rand_below(5));
        return log_reg_t'(rand_below(32));
    endfunction

    function automatic word_t model_alu(alu_op_t op, word_t a, word_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
        endcase
    endfunction

    task automatic check_rd(log_reg_t got, log_reg_t exp);
        if (got !== exp) begin
            $display("FAILED commit_rd: got %h expected %h (commit %0d)", got, exp, committed);
            rd_errors++;
        end
    endtask

    task automatic check_value(word_t got, word_t exp);
        if (got !== exp) begin
            $display("FAILED commit_value: got %h expected %h (commit %0d)",
                     got, exp, committed);
            value_errors++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            other_errors++;
        end
    endtask

    task automatic watch_commit();
        if (commit_valid) begin
            if (exp_rd.size() == 0) begin
                $display("commit of rd %0d arrived with no instruction outstanding", commit_rd);
                other_errors++;
            end else begin
                check_rd(commit_rd, exp_rd.pop_front());
                check_value(commit_value, exp_value.pop_front());
            end
            committed++;
        end
    endtask

    // outputs are stable and inputs change on the falling edge
    task automatic next_cycle();
        @(negedge clk);
        watch_commit();
    endtask

    task automatic drive_random();
        inst_op      = alu_op_t'(rand_below(8));
        inst_rs1     = pick_reg();
        inst_rs2     = pick_reg();
        inst_rd      = pick_reg();
        inst_use_imm = rand_below(3) == 0;
        inst_imm     = rand_below(2) == 0 ? word_t'(rand_below(64)) : word_t'($random(seed));
        inst_valid   = 1'b1;
    endtask

    task automatic record_dispatch();
        word_t a;
        word_t b;
        word_t res;
        a   = regs[inst_rs1];
        b   = inst_use_imm ? inst_imm : regs[inst_rs2];
        res = model_alu(inst_op, a, b);
        exp_rd.push_back(inst_rd);
        exp_value.push_back(res);
        if (inst_rd != '0)
            regs[inst_rd] = res;   // x0 stays zero
        sent++;
    endtask

    initial begin
        int burst;
        int gap;
        seed         = 32'h4d3;
        rst          = 1'b1;
        inst_valid   = 1'b0;
        inst_op      = ALU_ADD;
        inst_rs1     = '0;
        inst_rs2     = '0;
        inst_rd      = '0;
        inst_use_imm = 1'b0;
        inst_imm     = '0;
        sent         = 0;
        committed    = 0;
        stall_cycles = 0;
        rd_errors    = 0;
        value_errors = 0;
        other_errors = 0;
        for (int i = 0; i < `OOO_LOG_REGS; i++)
            regs[i] = '0;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        next_cycle();
        check_flag("stall", stall, 1'b0);
        check_flag("commit_valid", commit_valid, 1'b0);

        while (sent < N_INSTR) begin
            burst = 8 + rand_below(33);
            for (int k = 0; k < burst && sent < N_INSTR; k++) begin
                drive_random();
                // stall is stable until the next rising edge
                while (stall) begin
                    stall_cycles++;
                    next_cycle();
                end
                record_dispatch();
                next_cycle();
            end
            inst_valid = 1'b0;
            gap = rand_below(6);
            repeat (gap) next_cycle();
        end

        while (committed < sent)
            next_cycle();
        repeat (20) next_cycle();   // a stray commit would show up here

        if (committed != sent) begin
            $display("commit count %0d does not match dispatch count %0d", committed, sent);
            other_errors++;
        end
        if (exp_rd.size() != 0) begin
            $display("%0d instructions were never committed", exp_rd.size());
            other_errors++;
        end
        if (stall_cycles == 0) begin
            $display("stall never went high during the dispatch bursts");
            other_errors++;
        end

        $display("sent %0d committed %0d stall cycles %0d errors rd %0d value %0d other %0d",
                 sent, committed, stall_cycles, rd_errors, value_errors, other_errors);
        if (rd_errors + value_errors + other_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // 20 cycles per instruction plus reset
    initial begin
        #((N_INSTR * 20 + 16) * CLK_NS);
        $display("timeout: run did not finish, %0d of %0d instructions committed",
                 committed, sent);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- Makefile
# Verilator flow for the out-of-order core testbench

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module tb_ooo_core

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_ooo_core -Mdir obj_dir
	./obj_dir/Vtb_ooo_core > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Errors found" sim.log; then echo "simulation FAILED"; exit 1; fi
	@grep -q "No errors" sim.log || (echo "simulation FAILED, run did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- project.f
+incdir+rtl
rtl/ooo_pkg.sv
rtl/free_list.sv
rtl/rename_stage.sv
rtl/issue_queue.sv
rtl/alu_exec.sv
rtl/reorder_buffer.sv
rtl/ooo_core_top.sv
sim/tb_ooo_core.sv
